//--- source/counter_pkg.sv
// Register map assumes a 32-bit bus and two readable count registers; RAM words are 18 bits
`default_nettype none

package counter_pkg;

   localparam int data_w     = 32;
   localparam int bin_addr_w = 12;
   localparam int bin_data_w = 18;
   localparam int trig_w     = 8;
   localparam int reps_w     = 16;

   // Register offsets
   localparam logic [data_w-1:0] reg_ctrl     = 32'h00;
   localparam logic [data_w-1:0] reg_timeout  = 32'h04;
   localparam logic [data_w-1:0] reg_count0   = 32'h08;
   localparam logic [data_w-1:0] reg_count1   = 32'h0C;
   localparam logic [data_w-1:0] reg_bins     = 32'h10;
   localparam logic [data_w-1:0] reg_reps     = 32'h14;
   localparam logic [data_w-1:0] reg_predelay = 32'h18;
   localparam logic [data_w-1:0] reg_trig     = 32'h1C;
   localparam logic [data_w-1:0] reg_bin_ptr  = 32'h20;
   localparam logic [data_w-1:0] reg_rep_idx  = 32'h24;
   localparam logic [data_w-1:0] ram_base     = 32'h1_0000; // Bit 14 channel, bits 13:2 bin

   typedef enum logic [2:0] {
      cmd_none       = 3'd0,
      cmd_idle       = 3'd1,
      cmd_reset      = 3'd2,
      cmd_count_now  = 3'd3,
      cmd_count_trig = 3'd4,
      cmd_trigger    = 3'd6
   } cmd_e;

   // Code is visible in the control register
   typedef enum logic [3:0] {
      st_idle          = 4'd0,
      st_now_start     = 4'd1,
      st_now_wait      = 4'd2,
      st_trig_wait     = 4'd3,
      st_trig_store    = 4'd4,
      st_trig_predelay = 4'd5,
      st_trig_prestore = 4'd6,
      st_trig_window   = 4'd7
   } state_e;

   typedef struct packed {
      logic [data_w-1:0]     timeout;
      logic [data_w-1:0]     predelay;
      logic [bin_addr_w-1:0] bins_in_use;
      logic [reps_w-1:0]     repetitions;
   } meas_cfg_t;

   // Field order matches the trigger register, mask in the low byte
   typedef struct packed {
      logic              polarity;
      logic [trig_w-1:0] invert;
      logic [trig_w-1:0] mask;
   } trig_cfg_t;

   typedef struct packed {
      logic [bin_addr_w-1:0] addr;
      logic [bin_data_w-1:0] wdata;
      logic                  we;
   } ram_port_t;

endpackage

`default_nettype wire

//--- source/trigger_detect.sv
// Inputs are asynchronous and synchronized here; only the low trig_w inputs can take part
`timescale 1ns/100ps
`default_nettype none

module trigger_detect #(
   parameter int num_inputs = 4
) (
   input  wire                         i_clk,
   input  wire                         i_rstn,
   input  wire [num_inputs-1:0]        i_inputs,
   input  wire counter_pkg::trig_cfg_t i_trig_cfg,
   output logic                        o_trigger
);
   import counter_pkg::*;

   logic [num_inputs-1:0] sync_meta;
   logic [num_inputs-1:0] sync_q;
   logic [trig_w-1:0]     sel_bits;     // Inverted inputs that pass the mask
   logic                  trig_level;
   logic                  trig_level_q; // Level of the previous cycle

   assign sel_bits   = (trig_w'(sync_q) ^ i_trig_cfg.invert) & i_trig_cfg.mask;
   assign trig_level = ((|sel_bits) == i_trig_cfg.polarity);

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         sync_meta    <= '0;
         sync_q       <= '0;
         trig_level_q <= 1'b0;
         o_trigger    <= 1'b0;
      end else begin
         sync_meta    <= i_inputs;
         sync_q       <= sync_meta;
         trig_level_q <= trig_level;
         o_trigger    <= trig_level && !trig_level_q; // One pulse per rising level
      end
   end

endmodule

`default_nettype wire

//--- source/pulse_counter.sv
// Input is sampled asynchronously; high or low phases shorter than one clock can be missed
`timescale 1ns/100ps
`default_nettype none

module pulse_counter (
   input  wire                            i_clk,
   input  wire                            i_rstn,
   input  wire                            i_signal,
   input  wire                            i_clear,
   output logic [counter_pkg::data_w-1:0] o_count
);

   logic [1:0] sync;   // Two-flop synchronizer
   logic       sync_d; // Edge register

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         sync    <= '0;
         sync_d  <= 1'b0;
         o_count <= '0;
      end else begin
         sync   <= {sync[0], i_signal};
         sync_d <= sync[1];
         if (i_clear)
            o_count <= '0;
         else if (sync[1] && !sync_d)
            o_count <= o_count + 1'b1; // Wraps at 32 bits
      end
   end

endmodule

`default_nettype wire

//--- source/count_sequencer.sv
// Window lasts timeout+1 cycles; histogram adds only the low 18 bits of each count
`timescale 1ns/100ps
`default_nettype none

module count_sequencer #(
   parameter int num_channels = 2
) (
   input  wire                                                  i_clk,
   input  wire                                                  i_rstn,
   input  wire counter_pkg::cmd_e                               i_cmd,
   input  wire                                                  i_cmd_valid,
   input  wire                                                  i_trigger,
   input  wire counter_pkg::meas_cfg_t                          i_meas_cfg,
   input  wire [num_channels-1:0][counter_pkg::data_w-1:0]      i_count,
   input  wire [num_channels-1:0][counter_pkg::bin_data_w-1:0]  i_ram_rdata,
   output logic                                                 o_count_clear,
   output counter_pkg::ram_port_t [num_channels-1:0]            o_ram_a,
   output counter_pkg::state_e                                  o_state,
   output logic [num_channels-1:0][counter_pkg::data_w-1:0]     o_last_count,
   output logic [counter_pkg::bin_addr_w-1:0]                   o_bin_ptr,
   output logic [counter_pkg::reps_w-1:0]                       o_rep_idx
);
   import counter_pkg::*;

   logic [data_w-1:0]                       clk_cnt;   // Predelay and timeout down counter
   logic [num_channels-1:0][bin_data_w-1:0] acc_wdata; // Bin plus last count
   logic                                    acc_we;
   logic                                    trig_evt;
   logic                                    mode_cmd;

   // Software trigger acts like a hardware pulse
   assign trig_evt = i_trigger || (i_cmd_valid && i_cmd == cmd_trigger);
   assign mode_cmd = i_cmd_valid && i_cmd != cmd_none && i_cmd != cmd_trigger;

   // Port A always points at the current bin so its read is ready by prestore
   always_comb begin
      for (int ch = 0; ch < num_channels; ch++) begin
         o_ram_a[ch].addr  = o_bin_ptr;
         o_ram_a[ch].wdata = acc_wdata[ch];
         o_ram_a[ch].we    = acc_we;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_state == st_trig_prestore) begin
         for (int ch = 0; ch < num_channels; ch++)
            acc_wdata[ch] <= i_ram_rdata[ch] + o_last_count[ch][bin_data_w-1:0];
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_state       <= st_idle;
         o_count_clear <= 1'b1;
         o_last_count  <= '0;
         o_bin_ptr     <= '0;
         o_rep_idx     <= '0;
         acc_we        <= 1'b0;
         clk_cnt       <= '0;
      end else if (mode_cmd) begin
         o_count_clear <= 1'b1; // Any mode change closes a running window
         acc_we        <= 1'b0;
         case (i_cmd)
            cmd_count_now:  o_state <= st_now_start;
            cmd_count_trig: o_state <= st_trig_wait;
            cmd_reset: begin
               o_bin_ptr <= '0;
               o_rep_idx <= '0;
               o_state   <= st_idle;
            end
            default:        o_state <= st_idle;
         endcase
      end else begin
         case (o_state)
            st_idle: begin
               o_count_clear <= 1'b1;
               acc_we        <= 1'b0;
            end
            st_now_start: begin
               clk_cnt       <= i_meas_cfg.timeout;
               o_count_clear <= 1'b0;
               o_state       <= st_now_wait;
            end
            st_now_wait: begin
               if (clk_cnt == '0) begin
                  o_last_count  <= i_count;
                  o_count_clear <= 1'b1;
                  o_state       <= st_idle;
               end else begin
                  clk_cnt <= clk_cnt - 1'b1;
               end
            end
            st_trig_wait: begin
               if (trig_evt && i_meas_cfg.predelay != '0) begin
                  clk_cnt <= i_meas_cfg.predelay - 1'b1;
                  o_state <= st_trig_predelay;
               end else if (trig_evt) begin
                  clk_cnt       <= i_meas_cfg.timeout;
                  o_count_clear <= 1'b0;
                  o_state       <= st_trig_window;
               end
            end
            st_trig_predelay: begin
               if (clk_cnt == '0) begin
                  clk_cnt       <= i_meas_cfg.timeout;
                  o_count_clear <= 1'b0;
                  o_state       <= st_trig_window;
               end else begin
                  clk_cnt <= clk_cnt - 1'b1;
               end
            end
            st_trig_window: begin
               if (clk_cnt == '0) begin
                  o_last_count  <= i_count;
                  o_count_clear <= 1'b1;
                  o_state       <= st_trig_prestore;
               end else begin
                  clk_cnt <= clk_cnt - 1'b1;
               end
            end
            st_trig_prestore: begin
               acc_we  <= 1'b1; // Write lands at the end of store
               o_state <= st_trig_store;
            end
            st_trig_store: begin
               acc_we  <= 1'b0;
               o_state <= st_trig_wait;
               if (o_rep_idx == i_meas_cfg.repetitions) begin
                  o_rep_idx <= '0;
                  o_bin_ptr <= (o_bin_ptr == i_meas_cfg.bins_in_use - 1'b1) ?
                               '0 : o_bin_ptr + 1'b1;
               end else begin
                  o_rep_idx <= o_rep_idx + 1'b1;
               end
            end
            default: o_state <= st_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/bin_memory.sv
// Read-first on both ports; same-address writes from both ports in one cycle keep port B data
`timescale 1ns/100ps
`default_nettype none

module bin_memory (
   input  wire                                i_clk,
   input  wire counter_pkg::ram_port_t        i_port_a,
   output logic [counter_pkg::bin_data_w-1:0] o_rdata_a,
   input  wire counter_pkg::ram_port_t        i_port_b,
   output logic [counter_pkg::bin_data_w-1:0] o_rdata_b
);
   import counter_pkg::*;

   localparam int depth = 2 ** bin_addr_w;

   logic [bin_data_w-1:0] mem [depth]; // Histogram bins

   // Port A accumulates, port B belongs to the bus
   always_ff @(posedge i_clk) begin
      o_rdata_a <= mem[i_port_a.addr];
      o_rdata_b <= mem[i_port_b.addr];
      if (i_port_a.we)
         mem[i_port_a.addr] <= i_port_a.wdata;
      if (i_port_b.we)
         mem[i_port_b.addr] <= i_port_b.wdata;
   end

endmodule

`default_nettype wire

//--- source/bus_regs.sv
// Count readback covers channels 0 and 1 only; RAM space selects channel by address bit 14
`timescale 1ns/100ps
`default_nettype none

module bus_regs #(
   parameter int num_channels          = 2,
   parameter int default_trigger_input = 4
) (
   input  wire                                                  i_clk,
   input  wire                                                  i_rstn,
   input  wire [counter_pkg::data_w-1:0]                        i_sys_addr,
   input  wire [counter_pkg::data_w-1:0]                        i_sys_wdata,
   input  wire                                                  i_sys_wen,
   input  wire                                                  i_sys_ren,
   output logic [counter_pkg::data_w-1:0]                       o_sys_rdata,
   output logic                                                 o_sys_ack,
   output logic                                                 o_sys_err,
   input  wire counter_pkg::state_e                             i_state,
   input  wire [num_channels-1:0][counter_pkg::data_w-1:0]      i_last_count,
   input  wire [counter_pkg::bin_addr_w-1:0]                    i_bin_ptr,
   input  wire [counter_pkg::reps_w-1:0]                        i_rep_idx,
   input  wire [num_channels-1:0][counter_pkg::bin_data_w-1:0]  i_ram_rdata,
   output counter_pkg::meas_cfg_t                               o_meas_cfg,
   output counter_pkg::trig_cfg_t                               o_trig_cfg,
   output counter_pkg::cmd_e                                    o_cmd,
   output logic                                                 o_cmd_valid,
   output counter_pkg::ram_port_t [num_channels-1:0]            o_ram_b
);
   import counter_pkg::*;

   logic              ram_hit;    // Address in the histogram window
   logic              ram_ch;
   logic              reg_mapped; // Register offset exists
   logic              wr_err;
   logic [data_w-1:0] rd_mux;
   logic [data_w-1:0] rdata_q;
   logic              ram_rd_q;   // Previous strobe was a RAM read
   logic              ram_ch_q;

   assign ram_hit = (i_sys_addr[data_w-1:15] == ram_base[data_w-1:15]);
   assign ram_ch  = i_sys_addr[14];
   assign wr_err  = i_sys_wen && !ram_hit && !reg_mapped;

   // Port B sees the strobe directly so read data lines up with the ack
   always_comb begin
      for (int ch = 0; ch < num_channels; ch++) begin
         o_ram_b[ch].addr  = i_sys_addr[bin_addr_w+1:2];
         o_ram_b[ch].wdata = i_sys_wdata[bin_data_w-1:0];
         o_ram_b[ch].we    = i_sys_wen && ram_hit && (int'(ram_ch) == ch);
      end
   end

   always_comb begin
      reg_mapped = 1'b1;
      rd_mux     = '0;
      case (i_sys_addr)
         reg_ctrl:     rd_mux = data_w'(i_state);
         reg_timeout:  rd_mux = o_meas_cfg.timeout;
         reg_count0:   rd_mux = i_last_count[0];
         reg_count1:   rd_mux = i_last_count[1];
         reg_bins:     rd_mux = data_w'(o_meas_cfg.bins_in_use);
         reg_reps:     rd_mux = data_w'(o_meas_cfg.repetitions);
         reg_predelay: rd_mux = o_meas_cfg.predelay;
         reg_trig:     rd_mux = data_w'(o_trig_cfg);
         reg_bin_ptr:  rd_mux = data_w'(i_bin_ptr);
         reg_rep_idx:  rd_mux = data_w'(i_rep_idx);
         default:      reg_mapped = 1'b0; // Reads back as zero
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_meas_cfg  <= '0;
         o_trig_cfg  <= '{polarity: 1'b1,
                          invert:   '0,
                          mask:     trig_w'(1 << (default_trigger_input - 1))};
         o_cmd       <= cmd_none;
         o_cmd_valid <= 1'b0;
         o_sys_ack   <= 1'b0;
         o_sys_err   <= 1'b0;
         rdata_q     <= '0;
         ram_rd_q    <= 1'b0;
         ram_ch_q    <= 1'b0;
      end else begin
         o_cmd_valid <= 1'b0;
         o_sys_ack   <= (i_sys_wen || i_sys_ren) && !wr_err;
         o_sys_err   <= wr_err;
         rdata_q     <= (i_sys_ren && !i_sys_wen && !ram_hit) ? rd_mux : '0;
         ram_rd_q    <= i_sys_ren && !i_sys_wen && ram_hit;
         ram_ch_q    <= ram_ch;
         if (i_sys_wen && !ram_hit) begin
            case (i_sys_addr)
               reg_ctrl: begin
                  // Unknown codes become a no-op command
                  o_cmd       <= (i_sys_wdata inside {32'd1, 32'd2, 32'd3, 32'd4, 32'd6}) ?
                                 cmd_e'(i_sys_wdata[2:0]) : cmd_none;
                  o_cmd_valid <= 1'b1;
               end
               reg_timeout:  o_meas_cfg.timeout     <= i_sys_wdata;
               reg_bins:     o_meas_cfg.bins_in_use <= i_sys_wdata[bin_addr_w-1:0];
               reg_reps:     o_meas_cfg.repetitions <= i_sys_wdata[reps_w-1:0];
               reg_predelay: o_meas_cfg.predelay    <= i_sys_wdata;
               reg_trig:     o_trig_cfg             <= i_sys_wdata[$bits(trig_cfg_t)-1:0];
               default: ; // Read-only or unmapped
            endcase
         end
      end
   end

   assign o_sys_rdata = ram_rd_q ? data_w'(i_ram_rdata[ram_ch_q]) : rdata_q;

endmodule

`default_nettype wire

//--- source/photon_counter_top.sv
// Needs num_channels of at least 2 for the count registers and at most 2 for RAM decoding
`timescale 1ns/100ps
`default_nettype none

module photon_counter_top #(
   parameter int num_channels          = 2,
   parameter int num_inputs            = 4,
   parameter int default_trigger_input = 4
) (
   input  wire                            i_clk,
   input  wire                            i_rstn,
   input  wire [num_inputs-1:0]           i_inputs,
   input  wire [counter_pkg::data_w-1:0]  i_sys_addr,
   input  wire [counter_pkg::data_w-1:0]  i_sys_wdata,
   input  wire                            i_sys_wen,
   input  wire                            i_sys_ren,
   output logic [counter_pkg::data_w-1:0] o_sys_rdata,
   output logic                           o_sys_ack,
   output logic                           o_sys_err
);
   import counter_pkg::*;

   meas_cfg_t                               meas_cfg;
   trig_cfg_t                               trig_cfg;
   cmd_e                                    cmd;
   logic                                    cmd_valid;
   logic                                    trigger;
   logic                                    count_clear;
   state_e                                  state;
   logic [bin_addr_w-1:0]                   bin_ptr;
   logic [reps_w-1:0]                       rep_idx;
   logic [num_channels-1:0][data_w-1:0]     count;
   logic [num_channels-1:0][data_w-1:0]     last_count;
   ram_port_t [num_channels-1:0]            ram_a;     // Accumulate side
   ram_port_t [num_channels-1:0]            ram_b;     // Bus side
   logic [num_channels-1:0][bin_data_w-1:0] rdata_a;
   logic [num_channels-1:0][bin_data_w-1:0] rdata_b;

   bus_regs #(
      .num_channels         (num_channels),
      .default_trigger_input(default_trigger_input)
   ) u_bus_regs (
      .i_clk       (i_clk),
      .i_rstn      (i_rstn),
      .i_sys_addr  (i_sys_addr),
      .i_sys_wdata (i_sys_wdata),
      .i_sys_wen   (i_sys_wen),
      .i_sys_ren   (i_sys_ren),
      .o_sys_rdata (o_sys_rdata),
      .o_sys_ack   (o_sys_ack),
      .o_sys_err   (o_sys_err),
      .i_state     (state),
      .i_last_count(last_count),
      .i_bin_ptr   (bin_ptr),
      .i_rep_idx   (rep_idx),
      .i_ram_rdata (rdata_b),
      .o_meas_cfg  (meas_cfg),
      .o_trig_cfg  (trig_cfg),
      .o_cmd       (cmd),
      .o_cmd_valid (cmd_valid),
      .o_ram_b     (ram_b)
   );

   trigger_detect #(
      .num_inputs(num_inputs)
   ) u_trigger_detect (
      .i_clk     (i_clk),
      .i_rstn    (i_rstn),
      .i_inputs  (i_inputs),
      .i_trig_cfg(trig_cfg),
      .o_trigger (trigger)
   );

   count_sequencer #(
      .num_channels(num_channels)
   ) u_count_sequencer (
      .i_clk        (i_clk),
      .i_rstn       (i_rstn),
      .i_cmd        (cmd),
      .i_cmd_valid  (cmd_valid),
      .i_trigger    (trigger),
      .i_meas_cfg   (meas_cfg),
      .i_count      (count),
      .i_ram_rdata  (rdata_a),
      .o_count_clear(count_clear),
      .o_ram_a      (ram_a),
      .o_state      (state),
      .o_last_count (last_count),
      .o_bin_ptr    (bin_ptr),
      .o_rep_idx    (rep_idx)
   );

   // Channel i counts input i
   for (genvar ch = 0; ch < num_channels; ch++) begin : g_channel
      pulse_counter u_pulse_counter (
         .i_clk   (i_clk),
         .i_rstn  (i_rstn),
         .i_signal(i_inputs[ch]),
         .i_clear (count_clear),
         .o_count (count[ch])
      );

      bin_memory u_bin_memory (
         .i_clk    (i_clk),
         .i_port_a (ram_a[ch]),
         .o_rdata_a(rdata_a[ch]),
         .i_port_b (ram_b[ch]),
         .o_rdata_b(rdata_b[ch])
      );
   end

endmodule

`default_nettype wire

//--- sim/tb_photon_counter.sv
// Drives the default build of 2 channels and 4 inputs; pulse timing assumes windows above 50 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_photon_counter;
   import counter_pkg::*;

   logic              clk = 1'b0;
   logic              rstn;
   logic [3:0]        inputs;
   logic [data_w-1:0] sys_addr;
   logic [data_w-1:0] sys_wdata;
   logic              sys_wen;
   logic              sys_ren;
   logic [data_w-1:0] sys_rdata;
   logic              sys_ack;
   logic              sys_err;

   int          errors = 0;
   int          watchdog_cycles = 0;
   int          bin_sum [2][16];  // Expected histogram per channel and bin
   int          t_now;
   int          t_trig;
   int          pd;
   int          bins_b;
   int          reps_r;
   int          n_win;
   int          k0;
   int          k1;
   int          exp_ptr;
   int          exp_idx;
   logic [31:0] rd;
   logic [31:0] new_ptr;
   logic [31:0] new_idx;
   logic        got_ack;
   logic        got_err;

   always #50 clk = ~clk;

   photon_counter_top #(
      .num_channels         (2),
      .num_inputs           (4),
      .default_trigger_input(4)
   ) u_photon_counter_top (
      .i_clk      (clk),
      .i_rstn     (rstn),
      .i_inputs   (inputs),
      .i_sys_addr (sys_addr),
      .i_sys_wdata(sys_wdata),
      .i_sys_wen  (sys_wen),
      .i_sys_ren  (sys_ren),
      .o_sys_rdata(sys_rdata),
      .o_sys_ack  (sys_ack),
      .o_sys_err  (sys_err)
   );

   // One response per strobe, and none without one
   strobe_answered: assert property (@(posedge clk) disable iff (!rstn)
      (sys_wen || sys_ren) |=> (sys_ack != sys_err)) else begin
      errors++;
      $display("Bus strobe before %0t ns did not get exactly one ack or err", $time);
   end

   no_stray_response: assert property (@(posedge clk) disable iff (!rstn)
      !(sys_wen || sys_ren) |=> !(sys_ack || sys_err)) else begin
      errors++;
      $display("Bus response at %0t ns came without a strobe", $time);
   end

   task automatic issue_strobe(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic ack, output logic err);
      int waited;
      waited = 0;
      @(posedge clk);
      sys_addr  <= addr;
      sys_wdata <= wdata;
      sys_wen   <= wr;
      sys_ren   <= !wr;
      @(posedge clk);
      sys_wen <= 1'b0;
      sys_ren <= 1'b0;
      @(negedge clk); // Response is stable mid-cycle
      while (!(sys_ack || sys_err) && waited < 8) begin
         @(negedge clk);
         waited++;
      end
      rdata = sys_rdata;
      ack   = sys_ack;
      err   = sys_err;
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
      logic [31:0] dummy;
      logic        ack;
      logic        err;
      issue_strobe(1'b1, addr, data, dummy, ack, err);
      assert (ack && !err) else begin
         errors++;
         $display("Write to address 0x%h was not acknowledged", addr);
      end
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
      logic ack;
      logic err;
      issue_strobe(1'b0, addr, 32'h0, data, ack, err);
      assert (ack && !err) else begin
         errors++;
         $display("Read from address 0x%h was not acknowledged", addr);
      end
   endtask

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got == exp) else begin
         errors++;
         $display("Error at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
      end
   endtask

   task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp, input string what);
      logic [31:0] got;
      bus_read(addr, got);
      check_value(what, got, exp);
   endtask

   // Random value in, masked to the field width on readback
   task automatic roundtrip_field(input logic [31:0] addr, input logic [31:0] mask,
                                  input string what);
      logic [31:0] value;
      value = $urandom();
      bus_write(addr, value);
      expect_read(addr, value & mask, what);
   endtask

   task automatic command(input cmd_e c);
      bus_write(reg_ctrl, data_w'(c));
   endtask

   // Pulses 2 cycles high, 3 low
   task automatic drive_pulses(input int n0, input int n1);
      int nmax;
      nmax = (n0 > n1) ? n0 : n1;
      for (int i = 0; i < nmax; i++) begin
         @(posedge clk);
         inputs[0] <= (i < n0);
         inputs[1] <= (i < n1);
         repeat (2) @(posedge clk);
         inputs[0] <= 1'b0;
         inputs[1] <= 1'b0;
         repeat (2) @(posedge clk);
      end
   endtask

   task automatic blip_input(input int bit_no);
      @(posedge clk);
      inputs[bit_no] <= 1'b1;
      repeat (3) @(posedge clk);
      inputs[bit_no] <= 1'b0;
      repeat (6) @(posedge clk);
   endtask

   task automatic wait_idle();
      logic [31:0] st;
      int          polls;
      polls = 0;
      do begin
         bus_read(reg_ctrl, st);
         polls++;
      end while (st != 32'(st_idle) && polls < 1000);
      assert (st == 32'(st_idle)) else begin
         errors++;
         $display("Immediate run never returned to idle");
      end
   endtask

   task automatic poll_progress(input int old_ptr, input int old_idx,
                                output logic [31:0] ptr, output logic [31:0] idx);
      int polls;
      polls = 0;
      do begin
         bus_read(reg_bin_ptr, ptr);
         bus_read(reg_rep_idx, idx);
         polls++;
      end while (ptr == old_ptr && idx == old_idx && polls < 200);
      assert (ptr != old_ptr || idx != old_idx) else begin
         errors++;
         $display("Triggered window did not complete at %0t ns", $time);
      end
      bus_read(reg_bin_ptr, ptr); // Both fields settled now
      bus_read(reg_rep_idx, idx);
   endtask

   task automatic advance_model(inout int p, inout int r);
      if (r == reps_r) begin
         r = 0;
         p = (p == bins_b - 1) ? 0 : p + 1;
      end else begin
         r = r + 1;
      end
   endtask

   function automatic logic [31:0] ram_addr(input int ch, input int bin);
      return ram_base | (32'(ch) << 14) | (32'(bin) << 2);
   endfunction

   initial begin
      void'($urandom(3044));
      rstn      = 1'b0;
      inputs    = '0;
      sys_addr  = '0;
      sys_wdata = '0;
      sys_wen   = 1'b0;
      sys_ren   = 1'b0;
      k0        = $urandom_range(40, 1);
      k1        = $urandom_range(40, 1);
      t_now     = 250 + $urandom_range(100, 0);
      t_trig    = 50 + $urandom_range(20, 0);
      pd        = $urandom_range(12, 0);
      bins_b    = $urandom_range(4, 2);
      reps_r    = $urandom_range(2, 0);
      n_win     = bins_b * (reps_r + 1) + $urandom_range(bins_b, 1); // Forces a wrap
      watchdog_cycles = 5000 + 4 * t_now + (n_win + 2) * (pd + t_trig + 200);
      repeat (8) @(posedge clk);
      rstn <= 1'b1;
      repeat (2) @(posedge clk);

      // Register access
      expect_read(reg_trig, 32'h0001_0008, "Trigger reset value");
      roundtrip_field(reg_timeout, 32'hFFFF_FFFF, "Timeout");
      roundtrip_field(reg_predelay, 32'hFFFF_FFFF, "Predelay");
      roundtrip_field(reg_bins, 32'h0000_0FFF, "Bins in use");
      roundtrip_field(reg_reps, 32'h0000_FFFF, "Repetitions");
      roundtrip_field(reg_trig, 32'h0001_FFFF, "Trigger config");
      issue_strobe(1'b1, 32'h28, 32'h1234, rd, got_ack, got_err);
      assert (got_err && !got_ack) else begin
         errors++;
         $display("Write to unmapped offset 0x28 was not refused with err");
      end
      expect_read(32'h2C, 32'h0, "Unmapped read");

      // Immediate mode
      bus_write(reg_trig, 32'h0001_0000); // Empty mask, no hardware triggers
      bus_write(reg_timeout, t_now);
      command(cmd_count_now);
      repeat (4) @(posedge clk);
      drive_pulses(k0, k1);
      wait_idle();
      expect_read(reg_count0, k0, "Immediate count 0");
      expect_read(reg_count1, k1, "Immediate count 1");
      drive_pulses(3, 3);
      expect_read(reg_count0, k0, "Count 0 after window");

      // Triggered mode with histograms
      command(cmd_reset);
      bus_write(reg_bins, bins_b);
      bus_write(reg_reps, reps_r);
      bus_write(reg_timeout, t_trig);
      bus_write(reg_predelay, pd);
      for (int b = 0; b < bins_b; b++) begin
         bus_write(ram_addr(0, b), 32'h0);
         bus_write(ram_addr(1, b), 32'h0);
         bin_sum[0][b] = 0;
         bin_sum[1][b] = 0;
      end
      exp_ptr = 0;
      exp_idx = 0;
      command(cmd_count_trig);
      expect_read(reg_ctrl, 32'(st_trig_wait), "State in triggered mode");
      for (int i = 0; i < n_win; i++) begin
         k0 = $urandom_range(8, 0);
         k1 = $urandom_range(8, 0);
         bin_sum[0][exp_ptr] += k0;
         bin_sum[1][exp_ptr] += k1;
         command(cmd_trigger);
         repeat (pd + 3) @(posedge clk); // Past the predelay
         drive_pulses(k0, k1);
         poll_progress(exp_ptr, exp_idx, new_ptr, new_idx);
         advance_model(exp_ptr, exp_idx);
         check_value($sformatf("Bin pointer after window %0d", i), new_ptr, exp_ptr);
         check_value($sformatf("Repetition index after window %0d", i), new_idx, exp_idx);
      end
      expect_read(reg_count1, k1, "Last triggered count 1");
      for (int b = 0; b < bins_b; b++) begin
         expect_read(ram_addr(0, b), bin_sum[0][b], $sformatf("Channel 0 bin %0d", b));
         expect_read(ram_addr(1, b), bin_sum[1][b], $sformatf("Channel 1 bin %0d", b));
      end

      // Hardware trigger on input 3, inverted
      command(cmd_reset);
      bus_write(reg_trig, 32'h0001_0808);
      repeat (4) @(posedge clk);
      command(cmd_count_trig);
      blip_input(2);
      expect_read(reg_ctrl, 32'(st_trig_wait), "State after unselected input");
      blip_input(3); // Level rises as input 3 falls
      exp_ptr = 0;
      exp_idx = 0;
      poll_progress(exp_ptr, exp_idx, new_ptr, new_idx);
      advance_model(exp_ptr, exp_idx);
      check_value("Bin pointer after hardware trigger", new_ptr, exp_ptr);
      check_value("Repetition index after hardware trigger", new_idx, exp_idx);

      // Idle and reset commands
      command(cmd_count_trig);
      expect_read(reg_ctrl, 32'(st_trig_wait), "State before idle command");
      command(cmd_idle);
      expect_read(reg_ctrl, 32'(st_idle), "State after idle command");
      command(cmd_reset);
      expect_read(reg_bin_ptr, 32'h0, "Bin pointer after reset");
      expect_read(reg_rep_idx, 32'h0, "Repetition index after reset");

      repeat (4) @(posedge clk);
      $display("Summary: %0d errors", errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
source/counter_pkg.sv
source/trigger_detect.sv
source/pulse_counter.sv
source/count_sequencer.sv
source/bin_memory.sv
source/bus_regs.sv
source/photon_counter_top.sv
sim/tb_photon_counter.sv

//--- Makefile
SRCS := $(shell cat files.f)

.PHONY: all run lint clean

all: run

obj_dir/Vtb_photon_counter: files.f $(SRCS)
	verilator --binary --timing --assert -f files.f --top-module tb_photon_counter

run: obj_dir/Vtb_photon_counter
	obj_dir/Vtb_photon_counter | tee /dev/stderr | grep -qx "No errors"

lint:
	verilator --lint-only --timing -f files.f --top-module photon_counter_top

clean:
	rm -rf obj_dir
